//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/100ps -Wno-fatal
TOP       = tb_ql_periph
FILELIST  = tb.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG) || ! grep -q "TESTBENCH PASSED" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- common/ql_pkg.sv
package ql_pkg;

  // ==================================================
  // Register word addresses on the peripheral bus
  // ==================================================
  localparam logic [5:0] reg_timer   = 6'd0;   // Upper timer half on read
  localparam logic [5:0] reg_ipc     = 6'd1;   // Lower timer half on read
  localparam logic [5:0] reg_ipc_irq = 6'd16;
  localparam logic [5:0] reg_mdv     = 6'd17;
  localparam logic [5:0] reg_display = 6'd49;

  // IPC commands that are acted on
  typedef enum logic [3:0] {
    cmd_get_status = 4'd1,
    cmd_read_key   = 4'd8,
    cmd_read_row   = 4'd9,
    cmd_set_sound  = 4'd10,
    cmd_kill_sound = 4'd11
  } ipc_cmd_e;

  typedef enum logic [1:0] {
    ipc_idle,
    ipc_send,
    ipc_params,
    ipc_sound
  } ipc_state_e;

  typedef enum logic [1:0] {
    mdv_idle,
    mdv_gap,
    mdv_reading
  } mdv_state_e;

  // IPC return word, built as a key report and shifted out raw
  typedef union packed {
    struct packed {
      logic [3:0] tag;
      logic       zero_a;
      logic       shift;
      logic       ctrl;
      logic       alt;
      logic [1:0] zero_b;
      logic [2:0] row_n;    // Row sent inverted
      logic [2:0] col;
    } key;
    logic [15:0] raw;       // MSB goes out first
  } ipc_ret_u;

  typedef logic [9:0] mdv_addr_t;

endpackage

//--- ipc/ipc_link.sv
module ipc_link #(
  parameter int beep_tick = 1944
) (
  input  logic        i_clk_cpu,
  input  logic        i_reset,
  input  logic        i_wr_stb,
  input  logic        i_bit0,
  input  logic        i_bit1,
  input  logic [2:0]  i_row,
  input  logic [2:0]  i_col,
  input  logic        i_shift,
  input  logic        i_ctrl,
  input  logic        i_alt,
  input  logic [63:0] i_kbd_matrix,
  input  logic        i_key_down,
  output logic        o_ret_msb,
  output logic        o_beep_on,
  output logic [9:0]  o_pitch
);
  localparam int tick_w = $clog2(beep_tick + 1);

  ql_pkg::ipc_state_e state;
  ql_pkg::ipc_ret_u   ret;
  logic [5:0]         bit_cnt;
  logic [5:0]         last_bit;   // Index of the final bit in this phase
  logic [3:0]         cmd_sr;
  logic [63:0]        sound_sr;
  logic               key_pressed;
  logic [14:0]        duration;
  logic               timed;      // Zero duration runs until killed
  logic               start;
  logic [tick_w-1:0]  tick;
  logic               bit_wr;
  logic               last;
  logic [3:0]         cmd_nxt;
  logic [63:0]        sound_nxt;
  logic [14:0]        dur_nxt;

  assign bit_wr    = i_wr_stb && !i_bit0;   // Bit 0 high marks a start write
  assign last      = bit_cnt == last_bit;
  assign cmd_nxt   = {cmd_sr[2:0], i_bit1};
  assign sound_nxt = {sound_sr[62:0], i_bit1};
  assign dur_nxt   = {sound_nxt[22:16], sound_nxt[31:24]};
  assign o_ret_msb = ret.raw[15];

  always_ff @(posedge i_clk_cpu) begin
    if (i_reset) begin
      state       <= ql_pkg::ipc_idle;
      bit_cnt     <= 6'd0;
      key_pressed <= 1'b0;
      o_beep_on   <= 1'b0;
      start       <= 1'b0;
    end else begin
      start <= 1'b0;

      // ==================================================
      // Beep duration
      // ==================================================
      if (start) begin
        o_beep_on <= 1'b1;
        tick      <= '0;
      end else if (o_beep_on && timed) begin
        if (tick == tick_w'(beep_tick - 1)) begin
          tick <= '0;
          if (duration != 15'd0) begin
            duration <= duration - 15'd1;
          end else begin
            o_beep_on <= 1'b0;
          end
        end else begin
          tick <= tick + 1'b1;
        end
      end

      // ==================================================
      // Serial command engine
      // ==================================================
      if (bit_wr) begin
        cmd_sr  <= cmd_nxt;
        bit_cnt <= bit_cnt + 6'd1;
        case (state)
          ql_pkg::ipc_idle: begin
            if (bit_cnt == 6'd3) begin
              bit_cnt <= 6'd0;
              case (ql_pkg::ipc_cmd_e'(cmd_nxt))
                ql_pkg::cmd_get_status: begin
                  state       <= ql_pkg::ipc_send;
                  last_bit    <= 6'd7;
                  ret.raw     <= {7'd0, key_pressed, 8'd0};
                  key_pressed <= 1'b0;
                end
                ql_pkg::cmd_read_key: begin
                  state    <= ql_pkg::ipc_send;
                  last_bit <= 6'd15;
                  ret.key  <= '{4'b0001, 1'b0, i_shift, i_ctrl, i_alt, 2'b00, ~i_row, i_col};
                end
                ql_pkg::cmd_read_row: begin
                  state    <= ql_pkg::ipc_params;
                  last_bit <= 6'd3;
                end
                ql_pkg::cmd_set_sound: begin
                  state    <= ql_pkg::ipc_sound;
                  last_bit <= 6'd63;
                end
                ql_pkg::cmd_kill_sound: o_beep_on <= 1'b0;
                default: ;
              endcase
            end
          end
          ql_pkg::ipc_send: begin
            if (bit_cnt != 6'd0) begin
              ret.raw <= {ret.raw[14:0], 1'b0};
            end
            if (last) begin
              state   <= ql_pkg::ipc_idle;
              bit_cnt <= 6'd0;
            end
          end
          ql_pkg::ipc_params: begin
            if (last) begin   // Row number is complete
              state    <= ql_pkg::ipc_send;
              bit_cnt  <= 6'd0;
              last_bit <= 6'd7;
              ret.raw  <= {i_kbd_matrix[{cmd_nxt[2:0], 3'b000} +: 8], 8'd0};
            end
          end
          default: begin
            sound_sr <= sound_nxt;
            if (last) begin
              state     <= ql_pkg::ipc_idle;
              bit_cnt   <= 6'd0;
              o_pitch   <= 10'd256 - {2'b00, sound_nxt[63:56]};
              duration  <= dur_nxt;
              timed     <= dur_nxt != 15'd0;
              o_beep_on <= 1'b0;   // One quiet cycle before the new tone
              start     <= 1'b1;
            end
          end
        endcase
      end

      if (i_key_down) begin
        key_pressed <= 1'b1;
      end
    end
  end

  a_pitch_stable: assert property (@(posedge i_clk_cpu) disable iff (i_reset)
    o_beep_on && $past(o_beep_on) |-> $stable(o_pitch));

endmodule

//--- ipc/key_encoder.sv
module key_encoder (
  input  logic [63:0] i_kbd_matrix,
  output logic [2:0]  o_row,
  output logic [2:0]  o_col,
  output logic        o_shift,
  output logic        o_ctrl,
  output logic        o_alt
);
  logic [7:0] row_bits;
  logic       mod_mix;    // Modifiers down together with other row 7 keys

  // Lowest populated row wins, 7 when nothing is down
  always_comb begin
    o_row = 3'd7;
    for (int r = 6; r >= 0; r--) begin
      if (|i_kbd_matrix[r*8 +: 8]) begin
        o_row = 3'(r);
      end
    end
  end

  assign mod_mix  = (o_row == 3'd7) && (|i_kbd_matrix[58:56]) && (|i_kbd_matrix[63:59]);
  assign row_bits = i_kbd_matrix[{o_row, 3'b000} +: 8] & (mod_mix ? 8'hf8 : 8'hff);

  always_comb begin
    o_col = 3'd7;
    for (int c = 6; c >= 0; c--) begin
      if (row_bits[c]) begin
        o_col = 3'(c);
      end
    end
  end

  assign o_shift = i_kbd_matrix[56];
  assign o_ctrl  = i_kbd_matrix[57];
  assign o_alt   = i_kbd_matrix[58];

endmodule

//--- microdrive/mdv_stream.sv
module mdv_stream #(
  parameter int gap_cycles = 189000
) (
  input  logic              i_clk_cpu,
  input  logic              i_reset,
  input  logic              i_mctrl_wr,
  input  logic [7:0]        i_mctrl,
  input  logic              i_rd_stb,
  input  logic              i_host_wr,
  input  ql_pkg::mdv_addr_t i_host_addr,
  input  logic [7:0]        i_host_data,
  output logic [7:0]        o_byte,
  output logic              o_gap,
  output logic              o_unsel,
  output logic              o_mdv_req
);
  localparam int cnt_w = $clog2(gap_cycles + 1);

  logic [7:0]         buffer [0:1023];
  ql_pkg::mdv_state_e state;
  ql_pkg::mdv_addr_t  addr;
  logic [cnt_w-1:0]   gap_cnt;
  logic               gap_done;
  logic [7:0]         sel;         // Drive select shift register
  logic               clk_prev;    // mctrl bit 1 of the previous write

  // Host side of the buffer
  always_ff @(posedge i_clk_cpu) begin
    if (i_host_wr) begin
      buffer[i_host_addr] <= i_host_data;
    end
  end

  assign o_byte   = buffer[addr];
  assign o_gap    = state == ql_pkg::mdv_gap;
  assign o_unsel  = sel == 8'd0;
  assign gap_done = gap_cnt == cnt_w'(gap_cycles - 1);

  always_ff @(posedge i_clk_cpu) begin
    if (i_reset) begin
      state     <= ql_pkg::mdv_idle;
      gap_cnt   <= '0;
      sel       <= 8'd0;
      clk_prev  <= 1'b0;
      o_mdv_req <= 1'b0;
    end else begin
      o_mdv_req <= 1'b0;
      case (state)
        ql_pkg::mdv_gap: begin
          gap_cnt <= gap_done ? '0 : gap_cnt + 1'b1;
          if (gap_done) begin
            state     <= ql_pkg::mdv_reading;
            addr      <= '0;
            o_mdv_req <= 1'b1;   // Ask the host for the next block
          end
        end
        ql_pkg::mdv_reading: begin
          if (i_rd_stb) begin
            addr    <= addr + 1'b1;
            gap_cnt <= '0;
          end else if (gap_done) begin   // Data ran out
            state   <= ql_pkg::mdv_gap;
            gap_cnt <= '0;
          end else begin
            gap_cnt <= gap_cnt + 1'b1;
          end
        end
        default: ;
      endcase

      // Select clocks on the falling edge of mctrl bit 1
      if (i_mctrl_wr) begin
        clk_prev <= i_mctrl[1];
        if (clk_prev && !i_mctrl[1]) begin
          sel     <= {sel[6:0], i_mctrl[0]};
          gap_cnt <= '0;
          state   <= i_mctrl[0] ? ql_pkg::mdv_gap : ql_pkg::mdv_idle;
        end
      end
    end
  end

  a_req_pulse: assert property (@(posedge i_clk_cpu) disable iff (i_reset)
    o_mdv_req |=> !o_mdv_req);

endmodule

//--- source/io_regs.sv
module io_regs (
  input  logic        i_clk_cpu,
  input  logic        i_reset,
  input  logic        i_wr,
  input  logic        i_rd,
  input  logic [5:0]  i_addr,
  input  logic        i_uds,
  input  logic        i_lds,
  input  logic [15:0] i_wdata,
  input  logic        i_vsync,
  input  logic [31:0] i_timer,
  input  logic        i_ipc_msb,
  input  logic        i_mdv_gap,
  input  logic        i_mdv_unsel,
  input  logic [7:0]  i_mdv_byte,
  output logic [15:0] o_rdata,
  output logic        o_timer_rst,
  output logic        o_timer_adj,
  output logic        o_ipc_wr,
  output logic        o_mctrl_wr,
  output logic        o_mdv_rd,
  output logic        o_ipl1_n,
  output logic        o_mode
);
  logic       sel_timer;
  logic       sel_ipc;
  logic       sel_irq;
  logic       sel_mdv;
  logic       sel_disp;
  logic       irq_wr;      // Mask and acknowledge byte
  logic       vsync_q;
  logic       vsync_irq;
  logic       gap_irq;
  logic       mask_gap;    // Mask bit 0
  logic [7:0] status;
  logic [7:0] pending;

  assign sel_timer = i_addr == ql_pkg::reg_timer;
  assign sel_ipc   = i_addr == ql_pkg::reg_ipc;
  assign sel_irq   = i_addr == ql_pkg::reg_ipc_irq;
  assign sel_mdv   = i_addr == ql_pkg::reg_mdv;
  assign sel_disp  = i_addr == ql_pkg::reg_display;

  // Peer strobes, word write to the timer only resets it
  assign o_timer_rst = i_wr && sel_timer && i_uds;
  assign o_timer_adj = i_wr && sel_timer && i_lds && !i_uds;
  assign o_ipc_wr    = i_wr && sel_ipc && i_lds;
  assign o_mctrl_wr  = i_wr && sel_irq && i_uds;
  assign o_mdv_rd    = i_rd && sel_mdv;
  assign irq_wr      = i_wr && sel_irq && i_lds;

  assign status   = {i_ipc_msb, 3'b000, i_mdv_gap, 1'b1, 2'b00};   // Rx always ready
  assign pending  = {1'b0, i_mdv_unsel, i_timer[0], 1'b0, vsync_irq, 2'b00, gap_irq};
  assign o_ipl1_n = !(vsync_irq || gap_irq);

  // ==================================================
  // Interrupt flags, mask and display mode
  // ==================================================
  always_ff @(posedge i_clk_cpu) begin
    if (i_reset) begin
      vsync_q   <= 1'b0;
      vsync_irq <= 1'b0;
      gap_irq   <= 1'b0;
      mask_gap  <= 1'b0;
      o_mode    <= 1'b1;
    end else begin
      vsync_q <= i_vsync;
      if (irq_wr && i_wdata[3]) begin
        vsync_irq <= 1'b0;
      end else if (vsync_q && !i_vsync) begin   // Falling edge
        vsync_irq <= 1'b1;
      end
      if (irq_wr && i_wdata[0]) begin
        gap_irq <= 1'b0;
      end else if (i_mdv_gap && mask_gap) begin
        gap_irq <= 1'b1;
      end
      if (irq_wr) begin
        mask_gap <= i_wdata[5];   // Mask field is bits 7:5
      end
      if (i_wr && sel_disp && i_lds) begin
        o_mode <= i_wdata[3];
      end
    end
  end

  // Read data, held until the next read
  always_ff @(posedge i_clk_cpu) begin
    if (i_rd) begin
      case (i_addr)
        ql_pkg::reg_timer:   o_rdata <= i_timer[31:16];
        ql_pkg::reg_ipc:     o_rdata <= i_timer[15:0];
        ql_pkg::reg_ipc_irq: o_rdata <= {status, pending};
        ql_pkg::reg_mdv:     o_rdata <= {i_mdv_byte, i_mdv_byte};
        ql_pkg::reg_display: o_rdata <= {15'd0, o_mode};
        default:             o_rdata <= 16'd0;
      endcase
    end
  end

endmodule

//--- source/ql_periph_top.sv
module ql_periph_top #(
  parameter int clk_hz     = 27000000,
  parameter int gap_cycles = 189000,   // About 7 ms
  parameter int beep_tick  = 1944      // About 72 us per duration unit
) (
  input  logic              i_clk_cpu,
  input  logic              i_reset,
  input  logic              i_wr,
  input  logic              i_rd,
  input  logic [5:0]        i_addr,
  input  logic              i_uds,
  input  logic              i_lds,
  input  logic [15:0]       i_wdata,
  output logic [15:0]       o_rdata,
  input  logic              i_vsync,
  input  logic [63:0]       i_kbd_matrix,
  input  logic              i_key_down,
  input  logic              i_host_wr,
  input  ql_pkg::mdv_addr_t i_host_addr,
  input  logic [7:0]        i_host_data,
  output logic              o_mdv_req,
  output logic              o_ipl1_n,
  output logic              o_mode,
  output logic              o_beep_on,
  output logic [9:0]        o_pitch
);
  logic [31:0] timer;
  logic        timer_rst;
  logic        timer_adj;
  logic        ipc_wr;
  logic        mctrl_wr;
  logic        mdv_rd;
  logic        ipc_msb;
  logic        mdv_gap;
  logic        mdv_unsel;
  logic [7:0]  mdv_byte;
  logic [2:0]  key_row;
  logic [2:0]  key_col;
  logic        key_shift;
  logic        key_ctrl;
  logic        key_alt;

  io_regs u_io_regs (
    .i_clk_cpu   (i_clk_cpu),
    .i_reset     (i_reset),
    .i_wr        (i_wr),
    .i_rd        (i_rd),
    .i_addr      (i_addr),
    .i_uds       (i_uds),
    .i_lds       (i_lds),
    .i_wdata     (i_wdata),
    .i_vsync     (i_vsync),
    .i_timer     (timer),
    .i_ipc_msb   (ipc_msb),
    .i_mdv_gap   (mdv_gap),
    .i_mdv_unsel (mdv_unsel),
    .i_mdv_byte  (mdv_byte),
    .o_rdata     (o_rdata),
    .o_timer_rst (timer_rst),
    .o_timer_adj (timer_adj),
    .o_ipc_wr    (ipc_wr),
    .o_mctrl_wr  (mctrl_wr),
    .o_mdv_rd    (mdv_rd),
    .o_ipl1_n    (o_ipl1_n),
    .o_mode      (o_mode)
  );

  rtc_timer #(.clk_hz(clk_hz)) u_rtc_timer (
    .i_clk_cpu (i_clk_cpu),
    .i_reset   (i_reset),
    .i_rst_stb (timer_rst),
    .i_adj_stb (timer_adj),
    .i_byte    (i_wdata[7:0]),   // Adjust byte sits on the low lane
    .o_timer   (timer)
  );

  key_encoder u_key_encoder (
    .i_kbd_matrix (i_kbd_matrix),
    .o_row        (key_row),
    .o_col        (key_col),
    .o_shift      (key_shift),
    .o_ctrl       (key_ctrl),
    .o_alt        (key_alt)
  );

  ipc_link #(.beep_tick(beep_tick)) u_ipc_link (
    .i_clk_cpu    (i_clk_cpu),
    .i_reset      (i_reset),
    .i_wr_stb     (ipc_wr),
    .i_bit0       (i_wdata[0]),
    .i_bit1       (i_wdata[1]),
    .i_row        (key_row),
    .i_col        (key_col),
    .i_shift      (key_shift),
    .i_ctrl       (key_ctrl),
    .i_alt        (key_alt),
    .i_kbd_matrix (i_kbd_matrix),
    .i_key_down   (i_key_down),
    .o_ret_msb    (ipc_msb),
    .o_beep_on    (o_beep_on),
    .o_pitch      (o_pitch)
  );

  mdv_stream #(.gap_cycles(gap_cycles)) u_mdv_stream (
    .i_clk_cpu   (i_clk_cpu),
    .i_reset     (i_reset),
    .i_mctrl_wr  (mctrl_wr),
    .i_mctrl     (i_wdata[15:8]),   // mctrl rides the upper lane
    .i_rd_stb    (mdv_rd),
    .i_host_wr   (i_host_wr),
    .i_host_addr (i_host_addr),
    .i_host_data (i_host_data),
    .o_byte      (mdv_byte),
    .o_gap       (mdv_gap),
    .o_unsel     (mdv_unsel),
    .o_mdv_req   (o_mdv_req)
  );

endmodule

//--- source/rtc_timer.sv
module rtc_timer #(
  parameter int clk_hz = 27000000
) (
  input  logic        i_clk_cpu,
  input  logic        i_reset,
  input  logic        i_rst_stb,
  input  logic        i_adj_stb,
  input  logic [7:0]  i_byte,
  output logic [31:0] o_timer
);
  localparam int pre_w = $clog2(clk_hz + 1);

  logic [pre_w-1:0] prescaler;
  logic [1:0]       byte_ptr;    // Next byte to adjust

  always_ff @(posedge i_clk_cpu) begin
    if (i_reset) begin
      prescaler <= '0;
      byte_ptr  <= 2'd0;
      o_timer   <= 32'd0;
    end else begin
      // One second tick
      if (prescaler == pre_w'(clk_hz - 1)) begin
        prescaler <= '0;
        o_timer   <= o_timer + 32'd1;
      end else begin
        prescaler <= prescaler + 1'b1;
      end
      if (i_rst_stb) begin
        o_timer  <= 32'd0;
        byte_ptr <= 2'd0;
      end else if (i_adj_stb) begin
        o_timer[{byte_ptr, 3'b000} +: 8] <= i_byte;   // Low byte first
        byte_ptr <= byte_ptr + 2'd1;
      end
    end
  end

endmodule

//--- tb.f
common/ql_pkg.sv
source/rtc_timer.sv
source/io_regs.sv
ipc/key_encoder.sv
ipc/ipc_link.sv
microdrive/mdv_stream.sv
source/ql_periph_top.sv
testbench/tb_ql_periph.sv

//--- testbench/tb_ql_periph.sv
module tb_ql_periph;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int clk_hz     = 20;
  localparam int gap_cycles = 30;
  localparam int beep_tick  = 4;

  // IPC bit writes over all tests: two sounds, four keys, two rows, one kill
  localparam int ipc_writes     = 2 * (4 + 64) + 4 * (4 + 16) + 2 * (4 + 4 + 8) + 4;
  localparam int test_cycles    = 3 * clk_hz + 8 * gap_cycles + 4 * ipc_writes;
  localparam int timeout_cycles = 5 * test_cycles;   // Roughly 6500 cycles

  logic              clk_cpu;
  logic              reset;
  logic              wr;
  logic              rd;
  logic [5:0]        addr;
  logic              uds;
  logic              lds;
  logic [15:0]       wdata;
  logic [15:0]       rdata;
  logic              vsync;
  logic [63:0]       kbd_matrix;
  logic              key_down;
  logic              host_wr;
  ql_pkg::mdv_addr_t host_addr;
  logic [7:0]        host_data;
  logic              mdv_req;
  logic              ipl1_n;
  logic              mode;
  logic              beep_on;
  logic [9:0]        pitch;

  int          err_count;
  int          pass_count;
  int          fail_count;
  int          cycle_count;
  logic [31:0] rng_state;
  logic [9:0]  exp_pitch;   // Pitch the running beep must show
  logic        drive_sel;   // A drive is selected, requests allowed

  ql_periph_top #(
    .clk_hz     (clk_hz),
    .gap_cycles (gap_cycles),
    .beep_tick  (beep_tick)
  ) u_ql_periph_top (
    .i_clk_cpu    (clk_cpu),
    .i_reset      (reset),
    .i_wr         (wr),
    .i_rd         (rd),
    .i_addr       (addr),
    .i_uds        (uds),
    .i_lds        (lds),
    .i_wdata      (wdata),
    .o_rdata      (rdata),
    .i_vsync      (vsync),
    .i_kbd_matrix (kbd_matrix),
    .i_key_down   (key_down),
    .i_host_wr    (host_wr),
    .i_host_addr  (host_addr),
    .i_host_data  (host_data),
    .o_mdv_req    (mdv_req),
    .o_ipl1_n     (ipl1_n),
    .o_mode       (mode),
    .o_beep_on    (beep_on),
    .o_pitch      (pitch)
  );

  initial begin
    clk_cpu = 1'b0;
    forever #5 clk_cpu = ~clk_cpu;
  end

  // ==================================================
  // Concurrent checks
  // ==================================================
  a_beep_pitch: assert property (@(posedge clk_cpu) disable iff (reset)
    beep_on |-> pitch == exp_pitch)
    else begin
      $display("** Error at %0t ns: o_pitch = %0d, expected %0d", $time, pitch, exp_pitch);
      err_count++;
    end

  a_req_selected: assert property (@(posedge clk_cpu) disable iff (reset)
    mdv_req |-> drive_sel)
    else begin
      $display("o_mdv_req pulsed at %0t ns while no drive was selected", $time);
      err_count++;
    end

  // ==================================================
  // Helpers
  // ==================================================
  function automatic logic [31:0] xorshift_next();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // Key report for a single key at matrix bit k
  function automatic logic [15:0] key_report(input int k);
    logic [2:0] row;
    logic [2:0] col;
    row = 3'(k / 8);
    col = 3'(k % 8);
    return {4'b0001, 1'b0, k == 56, k == 57, k == 58, 2'b00, ~row, col};
  endfunction

  task automatic expect_equal(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    assert (got === exp)
      else begin
        $display("** Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
        err_count++;
      end
  endtask

  task automatic write_reg(input logic [5:0] reg_addr, input logic upper, input logic lower,
                           input logic [15:0] data);
    @(negedge clk_cpu);
    wr    = 1'b1;
    addr  = reg_addr;
    uds   = upper;
    lds   = lower;
    wdata = data;
    @(negedge clk_cpu);
    wr  = 1'b0;
    uds = 1'b0;
    lds = 1'b0;
  endtask

  task automatic read_reg(input logic [5:0] reg_addr, output logic [15:0] data);
    @(negedge clk_cpu);
    rd   = 1'b1;
    addr = reg_addr;
    @(negedge clk_cpu);
    rd   = 1'b0;
    data = rdata;   // Registered on the edge in between
  endtask

  task automatic load_buffer_byte(input ql_pkg::mdv_addr_t a, input logic [7:0] data);
    @(negedge clk_cpu);
    host_wr   = 1'b1;
    host_addr = a;
    host_data = data;
    @(negedge clk_cpu);
    host_wr = 1'b0;
  endtask

  // MSB first, bit 0 of the write kept low so every write counts
  task automatic send_ipc_bits(input logic [63:0] bits, input int n);
    for (int i = n - 1; i >= 0; i--) begin
      write_reg(ql_pkg::reg_ipc, 1'b0, 1'b1, {14'd0, bits[i], 1'b0});
    end
  endtask

  task automatic clock_out_bits(input int n, output logic [15:0] word);
    logic [15:0] d;
    word = '0;
    for (int i = 0; i < n; i++) begin
      write_reg(ql_pkg::reg_ipc, 1'b0, 1'b1, 16'h0002);
      read_reg(ql_pkg::reg_ipc_irq, d);
      word = {word[14:0], d[15]};   // Status bit 7
    end
  endtask

  // Select clocks on the falling edge of mctrl bit 1
  task automatic select_drive(input logic on);
    write_reg(ql_pkg::reg_ipc_irq, 1'b1, 1'b0, 16'h0200);
    write_reg(ql_pkg::reg_ipc_irq, 1'b1, 1'b0, {7'd0, on, 8'h00});
  endtask

  task automatic wait_beep(input logic level, input int limit, output int cycles);
    cycles = 0;
    while (beep_on !== level && cycles < limit) begin
      @(negedge clk_cpu);
      cycles++;
    end
    assert (beep_on === level)
      else begin
        $display("o_beep_on did not reach %0b within %0d cycles at %0t ns",
                 level, limit, $time);
        err_count++;
      end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    if (err_count == errs_before) begin
      pass_count++;
      $display("test %s: ok", name);
    end else begin
      fail_count++;
      $display("test %s: %0d errors", name, err_count - errs_before);
    end
  endtask

  // ==================================================
  // Stimulus
  // ==================================================
  initial begin
    int          errs;
    int          k;
    int          n;
    logic [31:0] r;
    logic [15:0] d;
    logic [15:0] t0;
    logic [15:0] t1;
    logic [15:0] step;
    logic [2:0]  row;
    logic [7:0]  pitch_byte;
    logic [63:0] sound;
    logic [7:0]  mdv_data [16];

    $timeformat(-9, 0, "", 0);
    reset      = 1'b1;
    wr         = 1'b0;
    rd         = 1'b0;
    addr       = '0;
    uds        = 1'b0;
    lds        = 1'b0;
    wdata      = '0;
    vsync      = 1'b0;
    kbd_matrix = '0;
    key_down   = 1'b0;
    host_wr    = 1'b0;
    host_addr  = '0;
    host_data  = '0;
    err_count  = 0;
    pass_count = 0;
    fail_count = 0;
    rng_state  = 32'd3995;
    exp_pitch  = '0;
    drive_sel  = 1'b0;
    repeat (3) @(posedge clk_cpu);
    @(negedge clk_cpu);
    reset = 1'b0;

    // Timer set and count
    errs = err_count;
    write_reg(ql_pkg::reg_timer, 1'b1, 1'b0, 16'h0000);   // Reset strobe
    r = xorshift_next();
    r[15] = 1'b0;   // No carry out of the low half while counting
    for (int b = 0; b < 4; b++) begin
      write_reg(ql_pkg::reg_timer, 1'b0, 1'b1, {8'h00, r[b*8 +: 8]});
    end
    read_reg(ql_pkg::reg_timer, d);
    expect_equal("o_rdata timer high", d, r[31:16]);
    read_reg(ql_pkg::reg_ipc, t0);
    repeat (3 * clk_hz - 4) @(negedge clk_cpu);   // Reads land 58 cycles apart
    read_reg(ql_pkg::reg_ipc, t1);
    step = t1 - t0;
    assert (step >= 16'd2 && step <= 16'd3)
      else begin
        $display("** Error at %0t ns: timer low step = %0d, expected 2 to 3", $time, step);
        err_count++;
      end
    finish_test("timer", errs);

    // Interrupts
    errs = err_count;
    expect_equal("o_mode", mode, 1'b1);   // Display mode out of reset
    @(negedge clk_cpu);
    vsync = 1'b1;
    @(negedge clk_cpu);
    vsync = 1'b0;
    @(negedge clk_cpu);
    read_reg(ql_pkg::reg_ipc_irq, d);
    expect_equal("pending vsync", d[3], 1'b1);
    expect_equal("o_ipl1_n", ipl1_n, 1'b0);
    write_reg(ql_pkg::reg_ipc_irq, 1'b0, 1'b1, 16'h0008);   // Acknowledge vsync
    read_reg(ql_pkg::reg_ipc_irq, d);
    expect_equal("pending vsync", d[3], 1'b0);
    expect_equal("o_ipl1_n", ipl1_n, 1'b1);
    write_reg(ql_pkg::reg_ipc_irq, 1'b0, 1'b1, 16'h0020);   // Mask bit 0 on
    drive_sel = 1'b1;
    select_drive(1'b1);
    repeat (4) @(negedge clk_cpu);
    read_reg(ql_pkg::reg_ipc_irq, d);
    expect_equal("pending gap", d[0], 1'b1);
    expect_equal("o_ipl1_n", ipl1_n, 1'b0);
    write_reg(ql_pkg::reg_ipc_irq, 1'b0, 1'b1, 16'h0001);   // Acknowledge, mask off
    read_reg(ql_pkg::reg_ipc_irq, d);
    expect_equal("pending gap", d[0], 1'b0);
    expect_equal("o_ipl1_n", ipl1_n, 1'b1);
    select_drive(1'b0);
    repeat (2) @(negedge clk_cpu);
    drive_sel = 1'b0;
    finish_test("interrupts", errs);

    // read_key, last pass on the shift key
    errs = err_count;
    for (int i = 0; i < 4; i++) begin
      k = (i == 3) ? 56 : int'(xorshift_next() % 64);
      @(negedge clk_cpu);
      kbd_matrix = 64'd1 << k;
      send_ipc_bits(64'(ql_pkg::cmd_read_key), 4);
      clock_out_bits(16, d);
      expect_equal("read_key report", d, key_report(k));
    end
    finish_test("read_key", errs);

    // read_row
    errs = err_count;
    for (int i = 0; i < 2; i++) begin
      @(negedge clk_cpu);
      kbd_matrix = {xorshift_next(), xorshift_next()};
      row = 3'(xorshift_next() % 8);
      send_ipc_bits(64'(ql_pkg::cmd_read_row), 4);
      send_ipc_bits({61'd0, row}, 4);
      clock_out_bits(8, d);
      expect_equal("read_row byte", d[7:0], kbd_matrix[row*8 +: 8]);
    end
    finish_test("read_row", errs);

    // Sound with duration 2, then untimed and killed
    errs = err_count;
    pitch_byte = 8'(xorshift_next());
    r = xorshift_next();
    exp_pitch = 10'd256 - {2'b00, pitch_byte};
    sound = {pitch_byte, r[23:0], 8'd2, r[31], 7'd0, r[15:0]};
    send_ipc_bits(64'(ql_pkg::cmd_set_sound), 4);
    send_ipc_bits(sound, 64);
    wait_beep(1'b1, 20, n);
    expect_equal("o_pitch", pitch, exp_pitch);
    wait_beep(1'b0, 40, n);
    assert (n >= 3 * beep_tick - 1 && n <= 3 * beep_tick + 1)
      else begin
        $display("** Error at %0t ns: beep length = %0d, expected %0d", $time, n,
                 3 * beep_tick);
        err_count++;
      end
    pitch_byte = 8'(xorshift_next());
    r = xorshift_next();
    exp_pitch = 10'd256 - {2'b00, pitch_byte};
    sound = {pitch_byte, r[23:0], 8'd0, r[31], 7'd0, r[15:0]};
    send_ipc_bits(64'(ql_pkg::cmd_set_sound), 4);
    send_ipc_bits(sound, 64);
    wait_beep(1'b1, 20, n);
    repeat (10 * beep_tick) @(negedge clk_cpu);
    expect_equal("o_beep_on untimed", beep_on, 1'b1);
    send_ipc_bits(64'(ql_pkg::cmd_kill_sound), 4);
    wait_beep(1'b0, 4, n);
    finish_test("sound", errs);

    // Microdrive stream
    errs = err_count;
    for (int a = 0; a < 16; a++) begin
      mdv_data[a] = 8'(xorshift_next());
      load_buffer_byte(ql_pkg::mdv_addr_t'(a), mdv_data[a]);
    end
    drive_sel = 1'b1;
    select_drive(1'b1);
    read_reg(ql_pkg::reg_ipc_irq, d);
    expect_equal("status gap", d[11], 1'b1);
    n = 0;
    while (!mdv_req && n < 2 * gap_cycles) begin
      @(negedge clk_cpu);
      n++;
    end
    assert (mdv_req)
      else begin
        $display("o_mdv_req never pulsed within %0d cycles of the select", 2 * gap_cycles);
        err_count++;
      end
    for (int a = 0; a < 16; a++) begin
      read_reg(ql_pkg::reg_mdv, d);
      expect_equal("mdv byte", d[7:0], mdv_data[a]);
    end
    read_reg(ql_pkg::reg_ipc_irq, d);
    expect_equal("status gap", d[11], 1'b0);
    finish_test("microdrive", errs);

    $display("summary: %0d tests passed, %0d failed, %0d errors", pass_count, fail_count,
             err_count);
    if (err_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    cycle_count = 0;
    while (cycle_count < timeout_cycles) begin
      @(posedge clk_cpu);
      cycle_count++;
    end
    $display("timeout: run went past %0d clock cycles", timeout_cycles);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule
